//--- files.f
logic/videoPkg.sv
logic/pixelCen.sv
logic/videoTiming.sv
logic/tileRender.sv
logic/lineBuffer.sv
logic/videoOut.sv
logic/videoTop.sv
tests/videoTop_assert.sv
tests/videoTop_tb.sv

//--- logic/lineBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module lineBuffer import videoPkg::*; (
    input  logic              clk,
    input  logic              cen,
    input  logic              wrEn,
    input  logic              wrBank,
    input  logic [ADDR_W-1:0] wrAddr,
    input  pixel_t            wrData,
    input  logic              rdBank,
    input  logic [ADDR_W-1:0] rdAddr,
    output pixel_t            rdData   // valid one tick after rdAddr
);

    // ping-pong storage
    // renderer and display always sit on opposite banks
    pixel_t mem [2][LINE_PIXELS];

    logic wrInRange;
    logic rdInRange;

    // the read side sweeps the whole line, blanked ticks fall outside
    assign wrInRange = wrAddr < ADDR_W'(LINE_PIXELS);
    assign rdInRange = rdAddr < ADDR_W'(LINE_PIXELS);

    // write port
    always_ff @(posedge clk) begin
        if (cen && wrEn && wrInRange) begin
            mem[wrBank][wrAddr] <= wrData;
        end
    end

    // registered read port
    // out of range reads return black
    always_ff @(posedge clk) begin
        if (cen) begin
            if (rdInRange) begin
                rdData <= mem[rdBank][rdAddr];
            end else begin
                rdData <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pixelCen.sv
`timescale 1ns/1ps
`default_nettype none

module pixelCen import videoPkg::*; (
    input  logic clk,
    input  logic reset,
    output logic cen    // one clk cycle in every CEN_DIV
);

    logic [CEN_W-1:0] cnt;   // position inside the pixel period
    logic             wrap;  // last clk cycle of the period

    assign wrap = cnt == CEN_W'(CEN_DIV - 1);

    // free running divider
    // cen is registered so every block sees a clean pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;                      // count restarts from zero
            cen <= 1'b0;
        end else begin
            cen <= wrap;                    // pulse right after the wrap
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tileRender.sv
`timescale 1ns/1ps
`default_nettype none

module tileRender import videoPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                cen,
    input  logic [H_W-1:0]      hdump,
    input  logic [V_W-1:0]      vrender,  // line to draw
    input  logic                start,
    input  logic [SCROLL_W-1:0] scroll,   // host value, may change any time
    output logic                wrEn,
    output logic                wrBank,
    output logic [ADDR_W-1:0]   wrAddr,
    output pixel_t              wrData
);

    logic [SCROLL_W-1:0] frameScroll;  // scroll used for the whole frame
    logic [H_W-1:0]      col;          // buffer column of this tick
    logic [H_W-1:0]      scrolled;     // column inside the pattern
    logic                inActive;
    logic                frameStart;
    pixel_t              pix;

    assign inActive   = (hdump >= H_ACTIVE_START) && (hdump < H_ACTIVE_END);
    assign col        = hdump - H_ACTIVE_START;
    assign scrolled   = col + H_W'(frameScroll);     // natural mod 512
    assign frameStart = start && (vrender == '0);

    // generated pattern
    // red steps with the column, green with the line
    // blue makes an 8x8 checkerboard
    always_comb begin
        pix.r = scrolled[7:3];
        pix.g = vrender[7:3];
        pix.b = {COLOR_W{scrolled[3] ^ vrender[3]}};
    end

    // scroll is only taken at the top of the rendered frame
    // so a host write never splits a picture
    always_ff @(posedge clk) begin
        if (reset) begin
            frameScroll <= '0;
        end else if (cen && frameStart) begin
            frameScroll <= scroll;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrEn <= 1'b0;
        end else if (cen) begin
            wrEn <= inActive;          // one write per visible tick
        end
    end

    // address, colour and bank of the pending write
    always_ff @(posedge clk) begin
        if (reset) begin
            wrAddr <= '0;
            wrData <= '0;
            wrBank <= 1'b0;
        end else if (cen) begin
            wrAddr <= ADDR_W'(col);
            wrData <= pix;
            wrBank <= vrender[0];      // line parity picks the bank
        end
    end

endmodule

`default_nettype wire

//--- logic/videoOut.sv
`timescale 1ns/1ps
`default_nettype none

module videoOut import videoPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  logic [H_W-1:0]    hdump,
    input  logic [V_W-1:0]    vdump,
    input  logic              HS,
    input  logic              VS,
    input  logic              HB,
    input  logic              VB,
    input  pixel_t            rdData,
    output logic              rdBank,
    output logic [ADDR_W-1:0] rdAddr,
    output pixel_t            rgb,
    output logic [H_W-1:0]    hpos,    // hdump two ticks late
    output logic [V_W-1:0]    vpos,
    output logic              HSo,
    output logic              VSo,
    output logic              HBo,
    output logic              VBo
);

    // first delay stage, matches the memory latency
    logic [H_W-1:0] hpos1;
    logic [V_W-1:0] vpos1;
    logic           HS1;
    logic           VS1;
    logic           HB1;
    logic           VB1;

    assign rdAddr = ADDR_W'(hdump - H_ACTIVE_START);
    assign rdBank = vdump[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            hpos1 <= '0;
            vpos1 <= '0;
            HS1   <= 1'b0;
            VS1   <= 1'b0;
            HB1   <= 1'b1;
            VB1   <= 1'b1;
            hpos  <= '0;
            vpos  <= '0;
            HSo   <= 1'b0;
            VSo   <= 1'b0;
            HBo   <= 1'b1;
            VBo   <= 1'b1;
            rgb   <= '0;
        end else if (cen) begin
            {hpos1, vpos1, HS1, VS1, HB1, VB1} <= {hdump, vdump, HS, VS, HB, VB};
            {hpos, vpos, HSo, VSo, HBo, VBo}   <= {hpos1, vpos1, HS1, VS1, HB1, VB1};
            rgb <= (HB1 || VB1) ? '0 : rdData;  // black outside the window
        end
    end

endmodule

`default_nettype wire

//--- logic/videoPkg.sv
`default_nettype none

package videoPkg;

    // pixel clock enable
    localparam int CEN_DIV = 4;           // clk cycles per pixel tick
    localparam int CEN_W   = 3;           // divider counter width

    // raster geometry in pixel ticks and lines
    localparam int H_W     = 9;           // horizontal count width
    localparam int V_W     = 9;           // vertical count width
    localparam int H_TOTAL = 512;         // ticks per line
    localparam int V_TOTAL = 262;         // lines per frame

    localparam logic [H_W-1:0] H_ACTIVE_START = 9'd64;
    localparam logic [H_W-1:0] H_ACTIVE_END   = 9'd448;  // 384 visible pixels
    localparam logic [V_W-1:0] V_ACTIVE_START = 9'd14;
    localparam logic [V_W-1:0] V_ACTIVE_END   = 9'd238;  // 224 visible lines

    // sync placement, moving HS_START up pulls the picture left
    localparam logic [H_W-1:0] HS_START = 9'd486;
    localparam int             HS_LEN   = 18;
    localparam logic [H_W-1:0] HS_END   = HS_START + H_W'(HS_LEN);  // wraps mod 512
    localparam logic [V_W-1:0] VS_START = 9'd251;
    localparam int             VS_LEN   = 4;
    localparam logic [V_W-1:0] VS_END   = VS_START + V_W'(VS_LEN);

    // line buffer
    localparam int LINE_PIXELS = 384;     // entries per bank
    localparam int ADDR_W      = 9;

    // host scroll register
    localparam int SCROLL_W = 9;

    // 15 bit colour, red in the top bits
    localparam int COLOR_W = 5;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } pixel_t;

endpackage

`default_nettype wire

//--- logic/videoTiming.sv
`timescale 1ns/1ps
`default_nettype none

module videoTiming import videoPkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           cen,
    output logic [H_W-1:0] hdump,    // pixel on screen now
    output logic [V_W-1:0] vdump,    // line on screen now
    output logic [V_W-1:0] vrender,  // line being drawn, one ahead of vdump
    output logic           start,    // first tick of a line
    output logic           HS,
    output logic           VS,
    output logic           HB,
    output logic           VB
);

    logic [V_W-1:0] vrender1;  // two lines ahead of vdump
    logic [H_W-1:0] hNext;     // hdump value after this tick
    logic           lineEnd;   // last tick of the line
    logic           vActive;   // displayed line is inside the window
    logic           hActiveNext;

    assign lineEnd = hdump == H_W'(H_TOTAL - 1);
    assign hNext   = lineEnd ? '0 : hdump + 1'b1;

    assign vActive = (vdump >= V_ACTIVE_START) && (vdump < V_ACTIVE_END);

    // HB is computed from the next count so it lines up with hdump
    assign hActiveNext = (hNext >= H_ACTIVE_START) && (hNext < H_ACTIVE_END);

    // raster counters
    // the line pipeline shifts once per line
    always_ff @(posedge clk) begin
        if (reset) begin
            hdump    <= '0;
            vdump    <= '0;
            vrender  <= V_W'(1);         // keeps vrender = vdump + 1
            vrender1 <= V_W'(2);
            start    <= 1'b0;
        end else if (cen) begin
            hdump <= hNext;
            start <= lineEnd;            // high while hdump is 0
            if (lineEnd) begin
                if (vrender1 == V_W'(V_TOTAL - 1)) begin
                    vrender1 <= '0;
                end else begin
                    vrender1 <= vrender1 + 1'b1;
                end
                vrender <= vrender1;
                vdump   <= vrender;
            end
        end
    end

    // sync and blanking levels
    always_ff @(posedge clk) begin
        if (reset) begin
            HS <= 1'b0;
            VS <= 1'b0;
            HB <= 1'b1;
            VB <= 1'b1;
        end else if (cen) begin
            HB <= !hActiveNext;
            if (hdump == HS_START) begin
                HS <= 1'b1;
                // vertical sync only moves together with a HS edge
                if (vdump == VS_START) begin
                    VS <= 1'b1;
                end
                if (vdump == VS_END) begin
                    VS <= 1'b0;
                end
            end
            if (hdump == HS_END) begin
                HS <= 1'b0;              // HS_LEN ticks after rising
            end
            // VB trails the window by one line
            if (lineEnd) begin
                VB <= !vActive;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/videoTop.sv
`timescale 1ns/1ps
`default_nettype none

module videoTop import videoPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [SCROLL_W-1:0] scroll,
    output pixel_t              rgb,
    output logic [H_W-1:0]      hpos,
    output logic [V_W-1:0]      vpos,
    output logic                HS,
    output logic                VS,
    output logic                HB,
    output logic                VB
);

    logic              cen;
    logic [H_W-1:0]    hdump;
    logic [V_W-1:0]    vdump;
    logic [V_W-1:0]    vrender;
    logic              start;
    logic              timHS;         // raw timing, before the output delay
    logic              timVS;
    logic              timHB;
    logic              timVB;
    logic              wrEn;
    logic              wrBank;
    logic [ADDR_W-1:0] wrAddr;
    pixel_t            wrData;
    logic              rdBank;
    logic [ADDR_W-1:0] rdAddr;
    pixel_t            rdData;

    pixelCen uCen (.clk(clk), .reset(reset), .cen(cen));

    videoTiming uTiming (
        .clk(clk), .reset(reset), .cen(cen),
        .hdump(hdump), .vdump(vdump), .vrender(vrender), .start(start),
        .HS(timHS), .VS(timVS), .HB(timHB), .VB(timVB)
    );

    // draws line vrender one line before it is shown
    tileRender uRender (
        .clk(clk), .reset(reset), .cen(cen),
        .hdump(hdump), .vrender(vrender), .start(start), .scroll(scroll),
        .wrEn(wrEn), .wrBank(wrBank), .wrAddr(wrAddr), .wrData(wrData)
    );

    lineBuffer uLineBuf (
        .clk(clk), .cen(cen),
        .wrEn(wrEn), .wrBank(wrBank), .wrAddr(wrAddr), .wrData(wrData),
        .rdBank(rdBank), .rdAddr(rdAddr), .rdData(rdData)
    );

    videoOut uOut (
        .clk(clk), .reset(reset), .cen(cen),
        .hdump(hdump), .vdump(vdump),
        .HS(timHS), .VS(timVS), .HB(timHB), .VB(timVB),
        .rdData(rdData), .rdBank(rdBank), .rdAddr(rdAddr),
        .rgb(rgb), .hpos(hpos), .vpos(vpos),
        .HSo(HS), .VSo(VS), .HBo(HB), .VBo(VB)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    -f files.f --top-module videoTop_tb -o videoTop_sim \
    && ./obj_dir/videoTop_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/videoTop_assert.sv
`timescale 1ns/1ps
`default_nettype none

module videoTop_assert import videoPkg::*; (
    input logic clk,
    input logic reset,
    input logic cen,
    input logic HS,
    input logic VS
);

    int         failCount = 0;
    logic [7:0] hsTicks;   // pixel ticks HS has been high so far

    always_ff @(posedge clk) begin
        if (reset) begin
            hsTicks <= '0;
        end else if (cen) begin
            hsTicks <= HS ? hsTicks + 1'b1 : '0;
        end
    end

    // HS pulse is exactly HS_LEN ticks wide
    hsWidth: assert property (@(posedge clk) disable iff (reset)
        $fell(HS) |-> hsTicks == 8'(HS_LEN))
        else begin
            failCount++;
            $error("HS fell after %0d ticks", hsTicks);
        end

    hsNotStuck: assert property (@(posedge clk) disable iff (reset)
        HS |-> hsTicks < 8'(HS_LEN))
        else begin
            failCount++;
            $error("HS high longer than its pulse width");
        end

    // VS only moves together with an HS rise
    vsOnHs: assert property (@(posedge clk) disable iff (reset)
        !$stable(VS) |-> $rose(HS))
        else begin
            failCount++;
            $error("VS changed away from an HS rise");
        end

endmodule

bind videoTiming videoTop_assert uAssert (
    .clk(clk), .reset(reset), .cen(cen),
    .HS(HS), .VS(VS)
);

`default_nettype wire

//--- tests/videoTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module videoTop_tb import videoPkg::*; ();

    localparam int FRAME_TICKS    = H_TOTAL * V_TOTAL;
    localparam int FRAME_CYCLES   = CEN_DIV * FRAME_TICKS;
    localparam int TEST_FRAMES    = 6;   // whole sequence ends just before the sixth frame is out
    localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_CYCLES * 11 / 10;  // plus 10%
    localparam int VISIBLE_PIXELS = LINE_PIXELS * (int'(V_ACTIVE_END) - int'(V_ACTIVE_START));
    localparam int SEL_HS = 0;
    localparam int SEL_VS = 1;
    localparam int SEL_VB = 2;

    logic                clk;
    logic                reset;
    logic [SCROLL_W-1:0] scroll;
    pixel_t              rgb;
    logic [H_W-1:0]      hpos;
    logic [V_W-1:0]      vpos;
    logic                HS;
    logic                VS;
    logic                HB;
    logic                VB;
    int                  valueErrors;
    int                  otherErrors;
    int                  cycles;
    logic [31:0]         rngState;

    videoTop uut (
        .clk(clk), .reset(reset), .scroll(scroll),
        .rgb(rgb), .hpos(hpos), .vpos(vpos),
        .HS(HS), .VS(VS), .HB(HB), .VB(VB)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;              // 20 ns period
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the raster tests did not finish in %0d clk cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected colour of pattern column col on line ln
    function automatic logic [3*COLOR_W-1:0] patternPixel(input logic [H_W-1:0] col,
                                                          input logic [V_W-1:0] ln,
                                                          input logic [SCROLL_W-1:0] scr);
        logic [H_W-1:0]     s;
        logic [COLOR_W-1:0] b;
        s = col + scr;                       // wraps at 512
        b = (s[3] != ln[3]) ? 5'd31 : 5'd0;  // checkerboard
        return {s[7:3], ln[7:3], b};
    endfunction

    function automatic logic syncLevel(input int sel);
        case (sel)
            SEL_HS:  return HS;
            SEL_VS:  return VS;
            default: return VB;
        endcase
    endfunction

    // outputs move once per pixel tick and hpos always changes then
    task automatic nextTick();
        logic [H_W-1:0] last;
        last = hpos;
        @(negedge clk);
        while (hpos == last) @(negedge clk);
    endtask

    task automatic waitRising(input int sel);
        logic prev;
        prev = syncLevel(sel);
        nextTick();
        while (!(syncLevel(sel) && !prev)) begin
            prev = syncLevel(sel);
            nextTick();
        end
    endtask

    task automatic comparePixel(input logic [SCROLL_W-1:0] scr);
        logic [3*COLOR_W-1:0] expected;
        expected = patternPixel(hpos - H_ACTIVE_START, vpos, scr);  // column from hpos
        if (rgb !== expected) begin
            $display("** Error: rgb = %h, expected %h at hpos %h vpos %h", rgb, expected,
                     hpos, vpos);
            valueErrors++;
        end
    endtask

    task automatic checkReset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if ({HS, VS, HB, VB} !== 4'b0011) begin   // syncs low, blanks high
            $display("** Error: {HS,VS,HB,VB} = %h, expected %h", {HS, VS, HB, VB}, 4'b0011);
            valueErrors++;
        end
        if (rgb !== '0) begin
            $display("** Error: rgb = %h, expected %h after reset", rgb, 15'h0);
            valueErrors++;
        end
    endtask

    // one line from an HS rise to the next
    task automatic checkLineTiming();
        int   period;
        int   hsTicks;
        int   hbLow;
        int   hbRuns;
        logic prevHS;
        logic prevHB;
        logic done;
        waitRising(SEL_HS);
        period = 0;
        hsTicks = 0;
        hbLow = 0;
        hbRuns = 0;
        prevHB = HB;
        done = 1'b0;
        while (!done) begin
            if (HS) hsTicks++;
            if (!HB) hbLow++;
            if (!HB && prevHB) begin
                hbRuns++;                   // start of a visible run
                if (hpos !== H_ACTIVE_START) begin
                    $display("** Error: hpos = %h, expected %h where HB falls", hpos,
                             H_ACTIVE_START);
                    valueErrors++;
                end
            end
            prevHS = HS;
            prevHB = HB;
            period++;
            nextTick();
            done = HS && !prevHS;
        end
        if (period != H_TOTAL) begin
            $display("** Error: HS period = %h, expected %h", period, H_TOTAL);
            valueErrors++;
        end
        if (hsTicks != HS_LEN) begin
            $display("** Error: HS high ticks = %h, expected %h", hsTicks, HS_LEN);
            valueErrors++;
        end
        if (hbLow != LINE_PIXELS || hbRuns != 1) begin
            $display("** Error: HB low ticks = %h in %h runs, expected %h in 1", hbLow, hbRuns,
                     LINE_PIXELS);
            valueErrors++;
        end
    endtask

    // lines are counted at HS rises, VS moves on those ticks too
    task automatic checkFrameTiming();
        int   lines;
        int   vsLines;
        int   vbLines;
        logic prevVS;
        logic done;
        waitRising(SEL_VS);
        if (vpos !== VS_START) begin
            $display("** Error: vpos = %h, expected %h where VS rises", vpos, VS_START);
            valueErrors++;
        end
        lines = 0;
        vsLines = 0;
        vbLines = 0;
        done = 1'b0;
        while (!done) begin
            if (VS) vsLines++;
            if (!VB) vbLines++;
            lines++;
            prevVS = VS;
            waitRising(SEL_HS);
            done = VS && !prevVS;
        end
        if (lines != V_TOTAL) begin
            $display("** Error: VS period lines = %h, expected %h", lines, V_TOTAL);
            valueErrors++;
        end
        if (vsLines != VS_LEN) begin
            $display("** Error: VS high lines = %h, expected %h", vsLines, VS_LEN);
            valueErrors++;
        end
        if (vbLines != VISIBLE_PIXELS / LINE_PIXELS) begin
            $display("** Error: VB low lines = %h, expected %h", vbLines,
                     VISIBLE_PIXELS / LINE_PIXELS);
            valueErrors++;
        end
    endtask

    task automatic checkBlanking();
        repeat (FRAME_TICKS) begin
            nextTick();
            if ((HB || VB) && rgb !== '0) begin
                $display("** Error: rgb = %h, expected %h in blanking at hpos %h vpos %h",
                         rgb, 15'h0, hpos, vpos);
                valueErrors++;
            end
        end
    endtask

    task automatic checkPicture();
        int pixels;
        pixels = 0;
        repeat (FRAME_TICKS) begin           // any full frame window holds every visible pixel
            nextTick();
            if (!HB && !VB) begin
                pixels++;
                comparePixel(scroll);
            end
        end
        if (pixels != VISIBLE_PIXELS) begin
            $display("** Error: visible pixels = %h, expected %h", pixels, VISIBLE_PIXELS);
            valueErrors++;
        end
    endtask

    task automatic checkScrollLatch();
        logic [SCROLL_W-1:0] oldScroll;
        logic [SCROLL_W-1:0] newScroll;
        logic                prevVB;
        int                  pixels;
        oldScroll = scroll;
        rngState = xorshift32(rngState);
        newScroll = rngState[SCROLL_W-1:0];
        if (newScroll == oldScroll) newScroll = oldScroll + 1'b1;   // force a visible shift
        while (vpos != 9'd100) nextTick();   // middle of the picture
        scroll = newScroll;
        prevVB = VB;
        while (!(VB && !prevVB)) begin       // rest of this frame keeps the old value
            if (!HB && !VB) comparePixel(oldScroll);
            prevVB = VB;
            nextTick();
        end
        pixels = 0;
        prevVB = VB;
        nextTick();
        while (!(VB && !prevVB)) begin       // next complete frame is shifted
            if (!HB && !VB) begin
                pixels++;
                comparePixel(newScroll);
            end
            prevVB = VB;
            nextTick();
        end
        if (pixels != VISIBLE_PIXELS) begin
            $display("scrolled frame was not seen in full, %0d of %0d pixels", pixels,
                     VISIBLE_PIXELS);
            otherErrors++;
        end
    endtask

    initial begin
        reset = 1'b1;
        scroll = '0;
        valueErrors = 0;
        otherErrors = 0;
        rngState = 32'h5e5f_b6e1;
        checkReset();
        checkLineTiming();
        checkFrameTiming();
        checkBlanking();
        checkPicture();
        checkScrollLatch();
        $display("errors: %0d value, %0d other, %0d assertion", valueErrors, otherErrors,
                 uut.uTiming.uAssert.failCount);
        if (valueErrors + otherErrors + uut.uTiming.uAssert.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
